// ==== design/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Bus and instruction widths
`define FETCH_AW 32
`define FETCH_BUS_DW 64
`define FETCH_INSN_DW 32

// Most bus words requested but not yet handed to the CPU
`define FETCH_LIMIT 16

// Response FIFO holds 2^LGFIFO bus words
`define FETCH_LGFIFO 4

// Outstanding read counter, bus full at 2^LGDEPTH-1
`define FETCH_LGDEPTH 8

// Byte address bits inside one bus word
`define FETCH_WORD_LSB 3

`endif

// ==== design/fetch_pkg.sv ====
`include "fetch_cfg.svh"
`default_nettype none

package fetch_pkg;

	//////////////////////////////////////////////////
	// Bus word, seen whole or as two instruction lanes
	//////////////////////////////////////////////////
	typedef union packed {
		logic [`FETCH_BUS_DW-1:0] raw;
		struct packed {
			// Later address in the word
			logic [`FETCH_INSN_DW-1:0] hi;
			// Earlier address in the word
			logic [`FETCH_INSN_DW-1:0] lo;
		} lane;
	} bus_word_u;

	// One FIFO slot, the error bit rides with the data
	typedef struct packed {
		logic      err;
		bus_word_u word;
	} fifo_entry_t;

	// Stream control from the CPU
	typedef struct packed {
		// New pc or clear, either one abandons the stream
		logic                 restart;
		logic                 clear;
		logic [`FETCH_AW-1:0] pc;
	} fetch_ctrl_t;

	// What the CPU sees
	typedef struct packed {
		logic                      valid;
		logic                      illegal;
		logic [`FETCH_AW-1:0]      pc;
		logic [`FETCH_INSN_DW-1:0] insn;
	} insn_out_t;

endpackage

`default_nettype wire

// ==== design/bus_tracker.sv ====
`include "fetch_cfg.svh"
`default_nettype none

module bus_tracker import fetch_pkg::*;
(
	input  logic        S_AXI_ACLK,
	input  logic        fifo_reset,
	input  fetch_ctrl_t i_ctrl,
	input  logic        i_ar_fire,
	input  logic        i_arvalid,
	input  logic        i_rvalid,
	output logic        o_flushing,
	output logic        o_flush_request,
	output logic        o_full_bus
);

	// One spare bit, a held request can push the flush count past the bus count
	localparam int cw = `FETCH_LGDEPTH + 1;
	localparam logic [cw-1:0] full_mark = cw'((1 << `FETCH_LGDEPTH) - 1);

	logic [cw-1:0] outstanding;
	logic [cw-1:0] next_outstanding;
	logic [cw-1:0] flushcount;
	logic [cw-1:0] new_flushcount;

	//////////////////////////////////////////////////
	// Outstanding reads
	//////////////////////////////////////////////////

	// Up on an accepted address, down on a response
	always_comb
	begin
		next_outstanding = outstanding;
		case ({ i_ar_fire, i_rvalid })
		2'b10: next_outstanding = outstanding + 1'b1;
		2'b01: next_outstanding = outstanding - 1'b1;
		default: next_outstanding = outstanding;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	if (fifo_reset)
	begin
		outstanding <= '0;
		o_full_bus  <= 1'b0;
	end
	else
	begin
		outstanding <= next_outstanding;
		// Registered, so it stops the next request
		o_full_bus  <= (next_outstanding >= full_mark);
	end

	//////////////////////////////////////////////////
	// Stale response flush
	//////////////////////////////////////////////////

	// Everything in flight, plus a request still held on AR,
	// less a response landing right now
	assign new_flushcount = outstanding + cw'(i_arvalid) - cw'(i_rvalid);

	always_ff @(posedge S_AXI_ACLK)
	if (fifo_reset)
	begin
		flushcount      <= '0;
		o_flushing      <= 1'b0;
		o_flush_request <= 1'b0;
	end
	else if (i_ctrl.restart)
	begin
		flushcount      <= new_flushcount;
		o_flushing      <= (new_flushcount != '0);
		// Held old request, its answer is stale too
		o_flush_request <= i_arvalid && !i_ar_fire;
	end
	else
	begin
		if (i_rvalid && (flushcount != '0))
		begin
			flushcount <= flushcount - 1'b1;
			// Last stale word just arrived
			o_flushing <= (flushcount > cw'(1));
		end

		// Held request finally went out
		if (i_ar_fire)
			o_flush_request <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== design/fetch_request.sv ====
`include "fetch_cfg.svh"
`default_nettype none

module fetch_request import fetch_pkg::*;
(
	input  logic                 S_AXI_ACLK,
	input  logic                 fifo_reset,
	input  fetch_ctrl_t          i_ctrl,
	input  logic                 i_arready,
	input  logic                 i_flush_request,
	input  logic                 i_full_bus,
	input  logic                 i_word_taken,
	input  logic                 i_hold,
	output logic                 o_arvalid,
	output logic [`FETCH_AW-1:0] o_araddr,
	output logic                 o_ar_fire
);

	localparam int fw = `FETCH_LGFIFO + 1;

	logic                 new_pc;
	logic                 active;
	logic                 pending_new_pc;
	logic [`FETCH_AW-1:0] pending_pc;
	logic [fw-1:0]        fill;
	logic [fw:0]          demand;
	logic                 throttle;
	logic                 ar_free;

	// Clear wins over a new pc
	assign new_pc    = i_ctrl.restart && !i_ctrl.clear;
	assign o_ar_fire = o_arvalid && i_arready;
	// AR may change only when idle or accepted
	assign ar_free   = !o_arvalid || i_arready;

	//////////////////////////////////////////////////
	// Request throttle
	//////////////////////////////////////////////////

	// Words requested and not yet popped by the unpacker
	// Flushed requests never land in the FIFO, so skip them
	always_ff @(posedge S_AXI_ACLK)
	if (fifo_reset || i_ctrl.restart)
		fill <= '0;
	else
	begin
		case ({ o_ar_fire && !i_flush_request, i_word_taken })
		2'b10: fill <= fill + 1'b1;
		2'b01: fill <= fill - 1'b1;
		default: fill <= fill;
		endcase
	end

	// Buffer fill, the request on AR and the word still at the output
	assign demand   = { 1'b0, fill } + (fw + 1)'(o_arvalid) + (fw + 1)'(i_hold);
	assign throttle = (demand >= (fw + 1)'(`FETCH_LIMIT));

	// Nothing is fetched until the CPU names a pc
	always_ff @(posedge S_AXI_ACLK)
	if (fifo_reset || i_ctrl.clear)
		active <= 1'b0;
	else if (new_pc)
		active <= 1'b1;

	//////////////////////////////////////////////////
	// AR channel
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	if (fifo_reset)
		o_arvalid <= 1'b0;
	else if (ar_free)
	begin
		o_arvalid <= active || new_pc;
		// A restart empties everything, old fill does not count
		if (!i_ctrl.restart && throttle)
			o_arvalid <= 1'b0;
		if (i_ctrl.clear || i_full_bus)
			o_arvalid <= 1'b0;
	end

	// New pc arrived while an address was stuck on the bus
	always_ff @(posedge S_AXI_ACLK)
	if (fifo_reset || i_ctrl.clear)
		pending_new_pc <= 1'b0;
	else if (ar_free)
		pending_new_pc <= 1'b0;
	else if (new_pc)
		pending_new_pc <= 1'b1;

	always_ff @(posedge S_AXI_ACLK)
	if (new_pc)
		pending_pc <= i_ctrl.pc;

	// Start at the pc itself, then walk aligned bus words
	always_ff @(posedge S_AXI_ACLK)
	if (ar_free)
	begin
		if (new_pc)
			o_araddr <= i_ctrl.pc;
		else if (pending_new_pc)
			o_araddr <= pending_pc;
		else if (o_arvalid)
		begin
			o_araddr[`FETCH_AW-1:`FETCH_WORD_LSB] <=
				o_araddr[`FETCH_AW-1:`FETCH_WORD_LSB] + 1'b1;
			o_araddr[`FETCH_WORD_LSB-1:0] <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== design/resp_fifo.sv ====
`include "fetch_cfg.svh"
`default_nettype none

module resp_fifo import fetch_pkg::*;
(
	input  logic                    S_AXI_ACLK,
	input  logic                    fifo_reset,
	input  logic                    i_restart,
	input  logic                    i_rvalid,
	input  logic                    i_flushing,
	input  logic [`FETCH_BUS_DW-1:0] i_rdata,
	input  logic [1:0]              i_rresp,
	input  logic                    i_pop,
	output fifo_entry_t             o_head,
	output logic                    o_empty
);

	localparam int depth = 1 << `FETCH_LGFIFO;

	fifo_entry_t              mem [depth];
	fifo_entry_t              wr_entry;
	logic [`FETCH_LGFIFO:0]   wr_ptr;
	logic [`FETCH_LGFIFO:0]   rd_ptr;
	logic                     full;
	logic                     do_write;
	logic                     do_read;

	//////////////////////////////////////////////////
	// Byte swap, bus order to instruction order
	//////////////////////////////////////////////////

	always_comb
	begin
		wr_entry.err = i_rresp[1];
		// Each 32-bit lane reversed on its own
		for (int gw = 0; gw < `FETCH_BUS_DW / 32; gw++)
			for (int gb = 0; gb < 4; gb++)
				wr_entry.word.raw[gw * 32 + (3 - gb) * 8 +: 8] =
					i_rdata[gw * 32 + gb * 8 +: 8];
	end

	// Stale responses never enter
	assign do_write = i_rvalid && !i_flushing && !full;
	assign do_read  = i_pop && !o_empty;

	// Extra pointer bit tells full from empty
	assign o_empty = (wr_ptr == rd_ptr);
	assign full    = (wr_ptr[`FETCH_LGFIFO] != rd_ptr[`FETCH_LGFIFO])
		&& (wr_ptr[`FETCH_LGFIFO-1:0] == rd_ptr[`FETCH_LGFIFO-1:0]);

	always_ff @(posedge S_AXI_ACLK)
	if (fifo_reset || i_restart)
	begin
		wr_ptr <= '0;
		rd_ptr <= '0;
	end
	else
	begin
		if (do_write)
			wr_ptr <= wr_ptr + 1'b1;
		if (do_read)
			rd_ptr <= rd_ptr + 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	if (do_write)
		mem[wr_ptr[`FETCH_LGFIFO-1:0]] <= wr_entry;

	// Head read straight out of the array
	assign o_head = mem[rd_ptr[`FETCH_LGFIFO-1:0]];

endmodule

`default_nettype wire

// ==== design/insn_unpack.sv ====
`include "fetch_cfg.svh"
`default_nettype none

module insn_unpack import fetch_pkg::*;
(
	input  logic        S_AXI_ACLK,
	input  logic        fifo_reset,
	input  fetch_ctrl_t i_ctrl,
	input  logic        i_ready,
	input  fifo_entry_t i_head,
	input  logic        i_empty,
	output logic        o_pop,
	output logic        o_word_taken,
	output logic        o_hold,
	output insn_out_t   o_insn_out
);

	logic                 new_pc;
	logic                 out_valid;
	logic                 out_illegal;
	logic [`FETCH_AW-1:0] out_pc;
	bus_word_u            out_word;
	logic [1:0]           lanes;
	logic                 first;
	logic                 shift;
	logic                 load;

	assign new_pc = i_ctrl.restart && !i_ctrl.clear;

	//////////////////////////////////////////////////
	// Pop control
	//////////////////////////////////////////////////

	// Output empty, or its last lane leaves this cycle
	assign o_pop        = !out_valid || (i_ready && (lanes <= 2'd1));
	assign load         = o_pop && !i_empty;
	assign o_word_taken = load;
	// Output keeps a word past this cycle
	assign o_hold       = out_valid && (!i_ready || (lanes > 2'd1));

	// Unaligned start skips the low lane of the first word
	assign shift = first ? out_pc[`FETCH_WORD_LSB-1] : 1'b0;

	always_ff @(posedge S_AXI_ACLK)
	if (fifo_reset)
		first <= 1'b0;
	else if (i_ctrl.restart)
		first <= new_pc;
	else if (load)
		first <= 1'b0;

	// Lanes left in the output word
	always_ff @(posedge S_AXI_ACLK)
	if (fifo_reset || i_ctrl.restart)
		lanes <= 2'd0;
	else if (o_pop)
		lanes <= i_empty ? 2'd0 : (2'd2 - { 1'b0, shift });
	else if (i_ready && (lanes != 2'd0))
		lanes <= lanes - 1'b1;

	always_ff @(posedge S_AXI_ACLK)
	if (fifo_reset || i_ctrl.restart)
		out_valid <= 1'b0;
	else if (!out_valid || i_ready)
		out_valid <= load || (lanes > (out_valid ? 2'd1 : 2'd0));

	//////////////////////////////////////////////////
	// Output data and address
	//////////////////////////////////////////////////

	// Low lane is always the one presented
	always_ff @(posedge S_AXI_ACLK)
	if (o_pop)
	begin
		out_word <= i_head.word;
		if (shift)
			out_word.lane.lo <= i_head.word.lane.hi;
	end
	else if (i_ready)
		out_word.lane.lo <= out_word.lane.hi;

	// Sticky bus error
	always_ff @(posedge S_AXI_ACLK)
	if (fifo_reset || i_ctrl.restart)
		out_illegal <= 1'b0;
	else if (!out_illegal && load)
		out_illegal <= i_head.err;

	// Freezes once illegal
	always_ff @(posedge S_AXI_ACLK)
	if (new_pc)
		out_pc <= i_ctrl.pc;
	else if (out_valid && i_ready && !out_illegal)
	begin
		out_pc[`FETCH_AW-1:2] <= out_pc[`FETCH_AW-1:2] + 1'b1;
		out_pc[1:0]           <= 2'b00;
	end

	assign o_insn_out = '{
		valid:   out_valid,
		illegal: out_illegal,
		pc:      out_pc,
		insn:    out_word.lane.lo
	};

endmodule

`default_nettype wire

// ==== design/axil_fetch.sv ====
`include "fetch_cfg.svh"
`default_nettype none

module axil_fetch import fetch_pkg::*;
(
	input  logic                     S_AXI_ACLK,
	input  logic                     fifo_reset,
	// CPU side
	input  logic                     i_new_pc,
	input  logic                     i_clear_cache,
	input  logic [`FETCH_AW-1:0]     i_pc,
	input  logic                     i_ready,
	output insn_out_t                o_insn_out,
	// AXI-lite read address
	output logic                     o_arvalid,
	output logic [`FETCH_AW-1:0]     o_araddr,
	input  logic                     i_arready,
	// AXI-lite read data, RREADY tied high
	input  logic                     i_rvalid,
	input  logic [`FETCH_BUS_DW-1:0] i_rdata,
	input  logic [1:0]               i_rresp
);

	fetch_ctrl_t ctrl;
	logic        ar_fire;
	logic        flushing;
	logic        flush_request;
	logic        full_bus;
	logic        pop;
	logic        empty;
	logic        word_taken;
	logic        hold;
	fifo_entry_t head;

	// Either input abandons the current stream
	assign ctrl = '{
		restart: i_new_pc || i_clear_cache,
		clear:   i_clear_cache,
		pc:      i_pc
	};

	//////////////////////////////////////////////////
	// Request side
	//////////////////////////////////////////////////

	bus_tracker bus_tracker_inst (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.fifo_reset      (fifo_reset),
		.i_ctrl          (ctrl),
		.i_ar_fire       (ar_fire),
		.i_arvalid       (o_arvalid),
		.i_rvalid        (i_rvalid),
		.o_flushing      (flushing),
		.o_flush_request (flush_request),
		.o_full_bus      (full_bus)
	);

	fetch_request fetch_request_inst (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.fifo_reset      (fifo_reset),
		.i_ctrl          (ctrl),
		.i_arready       (i_arready),
		.i_flush_request (flush_request),
		.i_full_bus      (full_bus),
		.i_word_taken    (word_taken),
		.i_hold          (hold),
		.o_arvalid       (o_arvalid),
		.o_araddr        (o_araddr),
		.o_ar_fire       (ar_fire)
	);

	//////////////////////////////////////////////////
	// Response side
	//////////////////////////////////////////////////

	resp_fifo resp_fifo_inst (
		.S_AXI_ACLK (S_AXI_ACLK),
		.fifo_reset (fifo_reset),
		.i_restart  (ctrl.restart),
		.i_rvalid   (i_rvalid),
		.i_flushing (flushing),
		.i_rdata    (i_rdata),
		.i_rresp    (i_rresp),
		.i_pop      (pop),
		.o_head     (head),
		.o_empty    (empty)
	);

	insn_unpack insn_unpack_inst (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.fifo_reset   (fifo_reset),
		.i_ctrl       (ctrl),
		.i_ready      (i_ready),
		.i_head       (head),
		.i_empty      (empty),
		.o_pop        (pop),
		.o_word_taken (word_taken),
		.o_hold       (hold),
		.o_insn_out   (o_insn_out)
	);

endmodule

`default_nettype wire

// ==== tests/clock_gen.sv ====
`default_nettype none

module clock_gen
(
	output logic o_clk,
	output logic o_reset
);

	// Period of 10
	initial
	begin
		o_clk = 1'b0;
		forever
			#5 o_clk = ~o_clk;
	end

	// Reset over the first 5 rising edges
	initial
	begin
		o_reset = 1'b1;
		repeat (5)
			@(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== tests/axil_fetch_tb.sv ====
`include "fetch_cfg.svh"
`default_nettype none

module axil_fetch_tb import fetch_pkg::*;
();

	// One read waiting in the slave in request order
	typedef struct packed {
		logic [`FETCH_AW-1:0] addr;
		logic [31:0]          due;
	} read_t;

	// One line of the case file
	typedef struct packed {
		logic [31:0] pc;
		logic [15:0] count;
		logic [31:0] err_addr;
		logic [3:0]  ar_stall;
		logic [3:0]  rdy_stall;
	} case_t;

	logic                     S_AXI_ACLK;
	logic                     fifo_reset;
	logic                     i_new_pc;
	logic                     i_clear_cache;
	logic [`FETCH_AW-1:0]     i_pc;
	logic                     i_ready;
	insn_out_t                o_insn_out;
	logic                     o_arvalid;
	logic [`FETCH_AW-1:0]     o_araddr;
	logic                     i_arready;
	logic                     i_rvalid;
	logic [`FETCH_BUS_DW-1:0] i_rdata;
	logic [1:0]               i_rresp;

	int          errors = 0;
	int          checked = 0;
	logic [31:0] cycles = '0;
	logic [31:0] cycle_limit = 32'd100;
	case_t       cases[$];
	read_t       reads[$];

	// Stream under test
	logic [31:0] stream_pc;
	logic [31:0] exp_pc;
	logic [31:0] err_addr = '1;
	logic [31:0] err_pc;
	int          taken;
	int          fires;
	int          passed;
	bit          counting;
	bit          err_seen;
	bit          taking;
	bit          held;
	insn_out_t   held_out;
	int unsigned ar_stall = 0;
	int unsigned rdy_stall = 0;

	clock_gen clock_gen_inst (
		.o_clk   (S_AXI_ACLK),
		.o_reset (fifo_reset)
	);

	axil_fetch axil_fetch_inst (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.fifo_reset    (fifo_reset),
		.i_new_pc      (i_new_pc),
		.i_clear_cache (i_clear_cache),
		.i_pc          (i_pc),
		.i_ready       (i_ready),
		.o_insn_out    (o_insn_out),
		.o_arvalid     (o_arvalid),
		.o_araddr      (o_araddr),
		.i_arready     (i_arready),
		.i_rvalid      (i_rvalid),
		.i_rdata       (i_rdata),
		.i_rresp       (i_rresp)
	);

	//////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////

	function automatic logic [31:0] swap_bytes(input logic [31:0] v);
		return { v[7:0], v[15:8], v[23:16], v[31:24] };
	endfunction

	// Lane at byte B reads back as B ^ A5A50000 once in instruction order
	function automatic logic [63:0] memory_word(input logic [31:0] addr);
		logic [31:0] base;
		base = { addr[31:3], 3'b000 };
		return { swap_bytes((base + 32'd4) ^ 32'hA5A50000), swap_bytes(base ^ 32'hA5A50000) };
	endfunction

	task automatic report_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		errors++;
	endtask

	//////////////////////////////////////////////////
	// In-order bus slave with random latency
	//////////////////////////////////////////////////

	task automatic serve_bus(input bit force_ar);
		read_t rd;
		if ((reads.size() != 0) && (reads[0].due <= cycles))
		begin
			rd = reads.pop_front();
			i_rvalid = 1'b1;
			i_rdata  = memory_word(rd.addr);
			// Whole error word answers with SLVERR
			if ((err_addr != '1) && (rd.addr[31:3] == err_addr[31:3]))
				i_rresp = 2'b10;
			else
				i_rresp = 2'b00;
		end
		else
		begin
			i_rvalid = 1'b0;
			i_rdata  = '0;
			i_rresp  = 2'b00;
		end
		i_arready = force_ar || (($urandom % 16) >= ar_stall);
		// Accepted at the coming edge
		if (o_arvalid && i_arready)
		begin
			rd.addr = o_araddr;
			rd.due  = cycles + 32'd1 + ($urandom % 4);
			reads.push_back(rd);
			// Requests of the new stream start at its own pc
			if (!counting && (o_araddr == stream_pc))
				counting = 1'b1;
			if (counting)
				fires++;
		end
	endtask

	//////////////////////////////////////////////////
	// CPU side checks
	//////////////////////////////////////////////////

	task automatic check_insn();
		checked++;
		if (o_insn_out.pc !== exp_pc)
			report_error($sformatf("pc %h, expected %h", o_insn_out.pc, exp_pc));
		if ((err_addr != '1) && (exp_pc[31:3] == err_addr[31:3]))
		begin
			if (!o_insn_out.illegal)
				report_error($sformatf("illegal low in error word at %h", exp_pc));
			err_seen = 1'b1;
			err_pc   = exp_pc;
		end
		else
		begin
			if (o_insn_out.illegal)
				report_error($sformatf("illegal high at %h", exp_pc));
			if (o_insn_out.insn !== (exp_pc ^ 32'hA5A50000))
				report_error($sformatf("insn %h at %h", o_insn_out.insn, exp_pc));
		end
		// High lane closes a bus word
		if (exp_pc[2])
			passed++;
		exp_pc = { exp_pc[31:2] + 30'd1, 2'b00 };
		taken++;
	endtask

	task automatic check_outputs();
		if (held && (o_insn_out !== held_out))
			report_error("output changed while i_ready was low");
		held     = o_insn_out.valid && !i_ready;
		held_out = o_insn_out;
		if (err_seen)
		begin
			// Frozen after a bus error
			if (o_insn_out.valid && (!o_insn_out.illegal || (o_insn_out.pc !== err_pc)))
				report_error($sformatf("pc %h after error at %h", o_insn_out.pc, err_pc));
		end
		else if (o_insn_out.valid && i_ready)
			check_insn();
		if (counting && !err_seen && ((fires - passed) > (`FETCH_LIMIT + 1)))
			report_error($sformatf("%0d words requested and not passed", fires - passed));
	endtask

	// All inputs change on the falling edge
	task automatic drive_cycle(input bit new_pc, input bit clear, input logic [31:0] pc);
		@(negedge S_AXI_ACLK);
		i_new_pc      = new_pc;
		i_clear_cache = clear;
		i_pc          = pc;
		serve_bus(clear);
		if (new_pc || clear)
		begin
			// Output is replaced at this edge
			i_ready = 1'b0;
			held    = 1'b0;
		end
		else
		begin
			i_ready = taking && (($urandom % 16) >= rdy_stall);
			check_outputs();
		end
	endtask

	//////////////////////////////////////////////////
	// Cases
	//////////////////////////////////////////////////

	task automatic read_cases();
		int          fd;
		int          n;
		string       line;
		case_t       c;
		logic [31:0] pc;
		logic [31:0] err;
		int          count;
		int          ar_s;
		int          rdy_s;
		fd = $fopen("tests/fetch_cases.txt", "r");
		if (fd == 0)
		begin
			$display("Test case file tests/fetch_cases.txt could not be opened");
			errors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			// Skip blank and column header lines
			if ((n > 0) && (line.len() > 1) && (line.getc(0) != "#"))
			begin
				n = $sscanf(line, "%h %d %h %d %d", pc, count, err, ar_s, rdy_s);
				if (n == 5)
				begin
					c.pc        = pc;
					c.count     = 16'(count);
					c.err_addr  = err;
					c.ar_stall  = 4'(ar_s);
					c.rdy_stall = 4'(rdy_s);
					cases.push_back(c);
				end
				else
				begin
					$display("Test case line could not be read: %s", line);
					errors++;
				end
			end
		end
		$fclose(fd);
		if (cases.size() == 0)
		begin
			$display("No test cases found in tests/fetch_cases.txt");
			errors++;
		end
	endtask

	task automatic run_case(input case_t c);
		stream_pc = c.pc;
		exp_pc    = c.pc;
		err_addr  = c.err_addr;
		ar_stall  = c.ar_stall;
		rdy_stall = c.rdy_stall;
		taken     = 0;
		fires     = 0;
		passed    = 0;
		counting  = 1'b0;
		err_seen  = 1'b0;
		// Older reads may still be in flight here
		drive_cycle(1'b1, 1'b0, c.pc);
		taking = 1'b1;
		while ((taken < int'(c.count)) && !err_seen)
			drive_cycle(1'b0, 1'b0, '0);
		if (err_seen)
			repeat (10)
				drive_cycle(1'b0, 1'b0, '0);
		taking = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		void'($urandom(32'h9d38));
		i_new_pc      = 1'b0;
		i_clear_cache = 1'b0;
		i_pc          = '0;
		i_ready       = 1'b0;
		i_arready     = 1'b0;
		i_rvalid      = 1'b0;
		i_rdata       = '0;
		i_rresp       = 2'b00;
		taking        = 1'b0;
		held          = 1'b0;
		counting      = 1'b0;
		err_seen      = 1'b0;
		stream_pc     = '0;
		read_cases();
		cycle_limit = 32'(400 * cases.size() + 100);

		while (fifo_reset !== 1'b0)
			@(negedge S_AXI_ACLK);

		// Idle until the first pc
		repeat (10)
		begin
			drive_cycle(1'b0, 1'b0, '0);
			if (o_arvalid || o_insn_out.valid)
				report_error("request or output active before any new pc");
		end

		foreach (cases[k])
			run_case(cases[k]);

		// Clear while AR is free and expect nothing to follow
		counting = 1'b0;
		drive_cycle(1'b0, 1'b1, '0);
		drive_cycle(1'b0, 1'b0, '0);
		if (o_insn_out.valid || o_arvalid)
			report_error("valid or arvalid high the cycle after clear");
		repeat (20)
		begin
			drive_cycle(1'b0, 1'b0, '0);
			if (o_insn_out.valid || o_arvalid)
				report_error("activity after clear");
		end

		$display("Instructions checked: %0d, errors: %0d", checked, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Cycle budget from the number of cases
	always @(posedge S_AXI_ACLK)
	begin
		cycles <= cycles + 32'd1;
		if (cycles >= cycle_limit)
		begin
			$display("Run stopped at the cycle limit of %0d before all cases ended", cycle_limit);
			$display("Instructions checked: %0d, errors: %0d", checked, errors + 1);
			$display("Finished with errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+design
design/fetch_pkg.sv
design/bus_tracker.sv
design/fetch_request.sv
design/resp_fifo.sv
design/insn_unpack.sv
design/axil_fetch.sv
tests/clock_gen.sv
tests/axil_fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module axil_fetch_tb \
	--Mdir obj_dir -o sim

output="$(./obj_dir/sim)"
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

// ==== tests/fetch_cases.txt ====
# start_pc count err_addr ar_stall ready_stall (hex, dec, hex, dec, dec)
# stall columns are low-period odds out of 16, err_addr ffffffff means no error word
00001000 40 ffffffff 0 0
00002004 33 ffffffff 0 0
00003000 50 ffffffff 5 0
00004004 45 ffffffff 0 6
00005008 60 ffffffff 7 9
00006000 20 ffffffff 0 12
00007004 40 00007040 3 3
00008000 40 0000801c 0 8
00009000 30 ffffffff 10 10
0000a00c 25 0000a010 4 4
